// ==== hdl/jesd_rx_regmap_pkg.sv ====
/*
 * JESD204 receive register map.
 * Word addresses on the 12-bit processor bus, bit positions of the
 * configuration and status fields, and their reset values.
 */
package jesd_rx_regmap_pkg;

  typedef logic [11:0] up_addr_t;     // bus word address.
  typedef logic [31:0] up_data_t;
  typedef logic [2:0] lane_addr_t;    // word offset inside a lane window.
  typedef logic [7:0] buffer_delay_t;

  // global words.
  localparam up_addr_t ADDR_BUFFER_SIZE = 12'h010;  // read only.
  localparam up_addr_t ADDR_RX_CFG = 12'h090;
  localparam up_addr_t ADDR_ERR_CTRL = 12'h091;
  localparam up_addr_t ADDR_STATUS = 12'h0a0;

  // lane n lives at LANE_BASE + 8 * n.
  localparam up_addr_t LANE_BASE = 12'h060;
  localparam lane_addr_t LANE_ADDR_STATUS = 3'd0;
  localparam lane_addr_t LANE_ADDR_ERR_CNT = 3'd1;
  localparam lane_addr_t LANE_ADDR_ILAS0 = 3'd4;  // ilas words at 4 to 7.

  localparam int CFG_EARLY_RELEASE_BIT = 16;
  localparam int CFG_DELAY_LSB = 2;  // delay counts whole beats of 4 octets.
  localparam int ERR_MASK_LSB = 8;
  localparam int ERR_CLEAR_BIT = 0;

  localparam int LANE_CGS_LSB = 0;
  localparam int LANE_EMB_LSB = 4;
  localparam int LANE_IFS_READY_BIT = 8;

  localparam int ELASTIC_BUFFER_SIZE = 256;  // octets.
  localparam buffer_delay_t RESET_BUFFER_DELAY = 8'd0;

endpackage

// ==== hdl/jesd_rx_status_pkg.sv ====
/*
 * JESD204 receive link status and control types.
 * Lane count, controller state and the bundles that cross
 * between the link core and the register block.
 */
package jesd_rx_status_pkg;

  localparam int NUM_LANES = 2;

  typedef enum logic [1:0] {
    WAIT = 2'd0,
    CGS  = 2'd1,
    ILAS = 2'd2,
    DATA = 2'd3
  } ctrl_state_e;

  typedef logic [1:0] cgs_state_t;
  typedef logic [2:0] emb_state_t;
  typedef logic [6:0] err_mask_t;   // one bit per 8b/10b error kind.
  typedef logic [31:0] err_cnt_t;
  typedef logic [31:0] ilas_data_t;

  typedef struct packed {
    cgs_state_t cgs_state;
    emb_state_t emb_state;
    logic       ifs_ready;
  } lane_status_s;

  typedef struct packed {
    ctrl_state_e                  ctrl_state;
    lane_status_s [NUM_LANES-1:0] lane;
    err_cnt_t [NUM_LANES-1:0]     err_cnt;
  } rx_status_s;

  typedef struct packed {
    err_mask_t mask;
    logic      clear;
  } err_ctrl_s;

  typedef struct packed {
    logic       valid;
    logic [1:0] addr;  // ilas word slot.
    ilas_data_t data;
  } ilas_word_s;

endpackage

// ==== hdl/cdc_bundle_sync.sv ====
/*
 * Multi-bit bundle synchronizer.
 * The source bundle is held in a register while a toggle crosses
 * to the destination and returns as an acknowledge, so all fields
 * arrive together. No reset; both sides power up at zero.
 */
`timescale 1ns/1ns

module cdc_bundle_sync #(
  parameter int WIDTH = 8
) (
  input  logic             in_clk,
  input  logic [WIDTH-1:0] in_data,
  input  logic             out_clk,
  output logic [WIDTH-1:0] out_data
);

  logic [WIDTH-1:0] in_hold = '0;
  logic             in_toggle = 1'b0;
  logic [1:0]       in_ack_sync = 2'b00;
  logic             in_ready;

  logic [1:0]       out_toggle_sync = 2'b00;
  logic             out_toggle = 1'b0;
  logic [WIDTH-1:0] out_hold = '0;

  // previous transfer acknowledged.
  assign in_ready = in_ack_sync[1] == in_toggle;

  always_ff @(posedge in_clk) begin
    in_ack_sync <= {in_ack_sync[0], out_toggle};
    if (in_ready) begin
      in_hold <= in_data;   // stays put until the ack returns.
      in_toggle <= ~in_toggle;
    end
  end

  always_ff @(posedge out_clk) begin
    out_toggle_sync <= {out_toggle_sync[0], in_toggle};
    if (out_toggle_sync[1] != out_toggle) begin
      out_toggle <= out_toggle_sync[1];
      out_hold <= in_hold;  // in_hold is stable here.
    end
  end

  assign out_data = out_hold;

endmodule

// ==== hdl/rx_err_stats.sv ====
/*
 * Per-lane 8b/10b error statistics.
 * Counts core_clk cycles with any unmasked error flag set,
 * saturating; clear holds every count at zero.
 */
`timescale 1ns/1ns

module rx_err_stats (
  input  logic                          core_clk,
  input  logic                          core_reset,
  input  jesd_rx_status_pkg::err_ctrl_s core_err_ctrl,
  input  jesd_rx_status_pkg::err_mask_t [jesd_rx_status_pkg::NUM_LANES-1:0]
                                        core_err_flags,
  output jesd_rx_status_pkg::err_cnt_t [jesd_rx_status_pkg::NUM_LANES-1:0]
                                        core_err_cnt
);

  logic [jesd_rx_status_pkg::NUM_LANES-1:0] err_hit;

  always_comb begin
    for (int i = 0; i < jesd_rx_status_pkg::NUM_LANES; i++) begin
      err_hit[i] = |(core_err_flags[i] & ~core_err_ctrl.mask);
    end
  end

  always_ff @(posedge core_clk) begin
    for (int i = 0; i < jesd_rx_status_pkg::NUM_LANES; i++) begin
      if (core_reset) begin
        core_err_cnt[i] <= '0;
      end else if (core_err_ctrl.clear) begin
        core_err_cnt[i] <= '0;
      end else if (err_hit[i] && core_err_cnt[i] != '1) begin
        core_err_cnt[i] <= core_err_cnt[i] + 1'b1;  // stop at max.
      end
    end
  end

  // counts only go up until software clears them.
  for (genvar i = 0; i < jesd_rx_status_pkg::NUM_LANES; i++) begin : gen_chk
    cnt_monotonic: assert property (@(posedge core_clk) disable iff (core_reset)
      !core_err_ctrl.clear |=> core_err_cnt[i] >= $past(core_err_cnt[i]))
      else $error("lane %0d error count decreased", i);
  end

endmodule

// ==== hdl/rx_lane_regs.sv ====
/*
 * Per-lane register window.
 * Captures the four ILAS configuration words in the core domain
 * and decodes the lane's read words for the bus.
 */
`timescale 1ns/1ns

module rx_lane_regs (
  input  logic                             up_clk,
  input  jesd_rx_regmap_pkg::lane_addr_t   up_raddr_lane,
  input  jesd_rx_status_pkg::lane_status_s up_lane_status,
  input  jesd_rx_status_pkg::err_cnt_t     up_err_cnt,
  output jesd_rx_regmap_pkg::up_data_t     lane_rdata,

  input  logic                             core_clk,
  input  logic                             core_reset,
  input  jesd_rx_status_pkg::ilas_word_s   core_ilas
);

  jesd_rx_status_pkg::ilas_data_t [3:0] ilas_word;

  // ilas config capture, one slot per word.
  always_ff @(posedge core_clk) begin
    if (!core_reset && core_ilas.valid) begin
      ilas_word[core_ilas.addr] <= core_ilas.data;
    end
  end

  always_comb begin
    lane_rdata = '0;
    if (up_raddr_lane == jesd_rx_regmap_pkg::LANE_ADDR_STATUS) begin
      lane_rdata[jesd_rx_regmap_pkg::LANE_CGS_LSB +: 2] = up_lane_status.cgs_state;
      lane_rdata[jesd_rx_regmap_pkg::LANE_EMB_LSB +: 3] = up_lane_status.emb_state;
      lane_rdata[jesd_rx_regmap_pkg::LANE_IFS_READY_BIT] = up_lane_status.ifs_ready;
    end else if (up_raddr_lane == jesd_rx_regmap_pkg::LANE_ADDR_ERR_CNT) begin
      lane_rdata = up_err_cnt;
    end else if (up_raddr_lane >= jesd_rx_regmap_pkg::LANE_ADDR_ILAS0) begin
      // words are only meaningful once the lane saw its ilas.
      if (up_lane_status.ifs_ready) begin
        lane_rdata = ilas_word[up_raddr_lane[1:0]];
      end
    end
  end

  /*
   * ifs_ready reaches up_clk through the status synchronizer, well after
   * the words settled, so the core-domain words can be read directly.
   */
  ilas_stable: assert property (@(posedge up_clk)
    up_lane_status.ifs_ready && $past(up_lane_status.ifs_ready) |-> $stable(ilas_word))
    else $error("ilas words changed while ifs_ready was seen high");

endmodule

// ==== hdl/rx_ctrl_regs.sv ====
/*
 * Global JESD204 receive registers.
 * Holds the link configuration and the error statistics control,
 * decodes bus writes and drives the registered read mux and the
 * one-cycle acknowledges.
 */
`timescale 1ns/1ns

module rx_ctrl_regs (
  input  logic                              up_clk,
  input  logic                              up_reset,

  input  logic                              up_rreq,
  input  jesd_rx_regmap_pkg::up_addr_t      up_raddr,
  output logic                              up_rack,
  output jesd_rx_regmap_pkg::up_data_t      up_rdata,
  input  logic                              up_wreq,
  input  jesd_rx_regmap_pkg::up_addr_t      up_waddr,
  input  jesd_rx_regmap_pkg::up_data_t      up_wdata,
  output logic                              up_wack,

  input  logic                              up_cfg_is_writeable,
  output jesd_rx_regmap_pkg::buffer_delay_t up_cfg_buffer_delay,
  output logic                              up_cfg_buffer_early_release,

  output jesd_rx_status_pkg::err_ctrl_s     up_err_ctrl,
  input  jesd_rx_status_pkg::rx_status_s    up_status,
  input  jesd_rx_regmap_pkg::up_data_t [jesd_rx_status_pkg::NUM_LANES-1:0]
                                            lane_rdata,
  output jesd_rx_regmap_pkg::lane_addr_t    up_raddr_lane
);

  jesd_rx_regmap_pkg::up_data_t rdata_next;

  assign up_raddr_lane = up_raddr[2:0];  // word offset within a lane.

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      up_cfg_buffer_delay <= jesd_rx_regmap_pkg::RESET_BUFFER_DELAY;
      up_cfg_buffer_early_release <= 1'b0;
      up_err_ctrl <= '0;
      up_wack <= 1'b0;
    end else begin
      up_wack <= up_wreq;
      if (up_wreq) begin
        case (up_waddr)
          jesd_rx_regmap_pkg::ADDR_RX_CFG: begin
            if (up_cfg_is_writeable) begin  // locked while the link runs.
              up_cfg_buffer_delay <= up_wdata[jesd_rx_regmap_pkg::CFG_DELAY_LSB +: 8];
              up_cfg_buffer_early_release <=
                up_wdata[jesd_rx_regmap_pkg::CFG_EARLY_RELEASE_BIT];
            end
          end
          jesd_rx_regmap_pkg::ADDR_ERR_CTRL: begin
            up_err_ctrl.mask <= up_wdata[jesd_rx_regmap_pkg::ERR_MASK_LSB +: 7];
            up_err_ctrl.clear <= up_wdata[jesd_rx_regmap_pkg::ERR_CLEAR_BIT];
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_next = '0;
    case (up_raddr)
      jesd_rx_regmap_pkg::ADDR_BUFFER_SIZE: begin
        rdata_next = 32'(jesd_rx_regmap_pkg::ELASTIC_BUFFER_SIZE);
      end
      jesd_rx_regmap_pkg::ADDR_RX_CFG: begin
        rdata_next[jesd_rx_regmap_pkg::CFG_EARLY_RELEASE_BIT] = up_cfg_buffer_early_release;
        rdata_next[jesd_rx_regmap_pkg::CFG_DELAY_LSB +: 8] = up_cfg_buffer_delay;
      end
      jesd_rx_regmap_pkg::ADDR_ERR_CTRL: begin
        rdata_next[jesd_rx_regmap_pkg::ERR_MASK_LSB +: 7] = up_err_ctrl.mask;
        rdata_next[jesd_rx_regmap_pkg::ERR_CLEAR_BIT] = up_err_ctrl.clear;
      end
      jesd_rx_regmap_pkg::ADDR_STATUS: begin
        rdata_next[1:0] = up_status.ctrl_state;
      end
      default: begin
        // lane windows, eight words each.
        for (int i = 0; i < jesd_rx_status_pkg::NUM_LANES; i++) begin
          if (up_raddr[11:3] == jesd_rx_regmap_pkg::LANE_BASE[11:3] + 9'(i)) begin
            rdata_next = lane_rdata[i];
          end
        end
      end
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rreq;
    end
  end

  // read data holds until the next acknowledge.
  always_ff @(posedge up_clk) begin
    if (up_rreq) begin
      up_rdata <= rdata_next;
    end
  end

  ack_has_req: assert property (@(posedge up_clk) disable iff (up_reset)
    (up_rack |-> $past(up_rreq)) and (up_wack |-> $past(up_wreq)))
    else $error("acknowledge without a request");

endmodule

// ==== hdl/jesd_rx_up.sv ====
/*
 * JESD204 receive register block top.
 * Bus registers on up_clk, status and counters from core_clk,
 * error statistics control back to core_clk, and one register
 * window per lane.
 */
`timescale 1ns/1ns

module jesd_rx_up (
  input  logic                              up_clk,
  input  logic                              up_reset,

  input  logic                              up_rreq,
  input  jesd_rx_regmap_pkg::up_addr_t      up_raddr,
  output logic                              up_rack,
  output jesd_rx_regmap_pkg::up_data_t      up_rdata,
  input  logic                              up_wreq,
  input  jesd_rx_regmap_pkg::up_addr_t      up_waddr,
  input  jesd_rx_regmap_pkg::up_data_t      up_wdata,
  output logic                              up_wack,

  input  logic                              up_cfg_is_writeable,
  output jesd_rx_regmap_pkg::buffer_delay_t up_cfg_buffer_delay,
  output logic                              up_cfg_buffer_early_release,

  input  logic                              core_clk,
  input  logic                              core_reset,
  input  jesd_rx_status_pkg::rx_status_s    core_status,  // err_cnt unused.
  input  jesd_rx_status_pkg::err_mask_t [jesd_rx_status_pkg::NUM_LANES-1:0]
                                            core_err_flags,
  input  jesd_rx_status_pkg::ilas_word_s [jesd_rx_status_pkg::NUM_LANES-1:0]
                                            core_ilas
);

  jesd_rx_status_pkg::rx_status_s up_status;
  jesd_rx_status_pkg::err_ctrl_s  up_err_ctrl;
  jesd_rx_status_pkg::err_ctrl_s  core_err_ctrl;
  jesd_rx_status_pkg::err_cnt_t [jesd_rx_status_pkg::NUM_LANES-1:0] core_err_cnt;
  jesd_rx_regmap_pkg::up_data_t [jesd_rx_status_pkg::NUM_LANES-1:0] lane_rdata;
  jesd_rx_regmap_pkg::lane_addr_t up_raddr_lane;

  rx_ctrl_regs i_ctrl_regs (
    .up_clk(up_clk), .up_reset(up_reset),
    .up_rreq(up_rreq), .up_raddr(up_raddr), .up_rack(up_rack), .up_rdata(up_rdata),
    .up_wreq(up_wreq), .up_waddr(up_waddr), .up_wdata(up_wdata), .up_wack(up_wack),
    .up_cfg_is_writeable(up_cfg_is_writeable),
    .up_cfg_buffer_delay(up_cfg_buffer_delay),
    .up_cfg_buffer_early_release(up_cfg_buffer_early_release),
    .up_err_ctrl(up_err_ctrl), .up_status(up_status),
    .lane_rdata(lane_rdata), .up_raddr_lane(up_raddr_lane));

  // core status with the counter values merged in.
  cdc_bundle_sync #(.WIDTH($bits(jesd_rx_status_pkg::rx_status_s))) i_cdc_status (
    .in_clk(core_clk),
    .in_data({core_status.ctrl_state, core_status.lane, core_err_cnt}),
    .out_clk(up_clk), .out_data(up_status));

  cdc_bundle_sync #(.WIDTH($bits(jesd_rx_status_pkg::err_ctrl_s))) i_cdc_err_ctrl (
    .in_clk(up_clk), .in_data(up_err_ctrl),
    .out_clk(core_clk), .out_data(core_err_ctrl));

  rx_err_stats i_err_stats (
    .core_clk(core_clk), .core_reset(core_reset), .core_err_ctrl(core_err_ctrl),
    .core_err_flags(core_err_flags), .core_err_cnt(core_err_cnt));

  for (genvar i = 0; i < jesd_rx_status_pkg::NUM_LANES; i++) begin : gen_lane
    rx_lane_regs i_lane_regs (
      .up_clk(up_clk), .up_raddr_lane(up_raddr_lane),
      .up_lane_status(up_status.lane[i]), .up_err_cnt(up_status.err_cnt[i]),
      .lane_rdata(lane_rdata[i]),
      .core_clk(core_clk), .core_reset(core_reset), .core_ilas(core_ilas[i]));
  end

endmodule

// ==== tests/tb_jesd_rx_up.sv ====
/*
 * Testbench for the JESD204 receive register block.
 * A step table of bus writes, reads and polls runs against the DUT
 * while a small link-core model drives status, error flags and ILAS.
 */
`timescale 1ns/1ns

module tb_jesd_rx_up;

  localparam int NL = jesd_rx_status_pkg::NUM_LANES;
  localparam int ACK_TIMEOUT = 8;     // up_clk cycles.
  localparam int POLL_TIMEOUT = 200;  // reads.
  localparam int SYNC_TIMEOUT = 100;  // core_clk cycles.

  typedef enum int {
    OP_WR, OP_RD, OP_POLL, OP_CFG, OP_STATUS, OP_SYNC, OP_FLAGS, OP_ILAS
  } op_e;

  typedef struct packed {
    op_e         op;
    logic [11:0] addr;
    logic [31:0] data;
    logic        wr_en;
    logic [31:0] exp;
    logic        use_cnt;  // expect the model count of the lane.
  } step_s;

  logic up_clk;
  logic core_clk;
  logic up_reset;
  logic core_reset;
  logic up_rreq;
  logic up_wreq;
  logic up_rack;
  logic up_wack;
  logic up_cfg_is_writeable;
  logic up_cfg_buffer_early_release;
  jesd_rx_regmap_pkg::up_addr_t up_raddr;
  jesd_rx_regmap_pkg::up_addr_t up_waddr;
  jesd_rx_regmap_pkg::up_data_t up_wdata;
  jesd_rx_regmap_pkg::up_data_t up_rdata;
  jesd_rx_regmap_pkg::buffer_delay_t up_cfg_buffer_delay;
  jesd_rx_status_pkg::rx_status_s core_status;
  jesd_rx_status_pkg::err_mask_t [NL-1:0] core_err_flags;
  jesd_rx_status_pkg::ilas_word_s [NL-1:0] core_ilas;

  step_s steps[$];
  int unsigned cnt_model [NL];
  logic [6:0] mask_model;
  int errors = 0;
  int checks = 0;

  jesd_rx_up DUT (.*);

  initial begin
    up_clk = 1'b0;
    forever #20 up_clk = ~up_clk;
  end

  initial begin
    core_clk = 1'b0;
    forever #12 core_clk = ~core_clk;
  end

  function automatic logic [11:0] lane_addr(input int lane, input int off);
    return jesd_rx_regmap_pkg::LANE_BASE + 12'(8 * lane + off);
  endfunction

  // readback layout of the rx config word.
  function automatic logic [31:0] cfg_word(input logic early, input logic [7:0] delay);
    return (32'(early) << 16) | (32'(delay) << 2);
  endfunction

  function automatic logic [31:0] lane_word(input int cgs, input int emb, input int ifs);
    return (32'(ifs) << 8) | (32'(emb) << 4) | 32'(cgs);
  endfunction

  function automatic logic [31:0] ilas_val(input int lane, input int slot);
    return 32'h5a00_00c3 | (32'(lane) << 16) | (32'(slot) << 8);
  endfunction

  task automatic add(input op_e op, input logic [11:0] addr, input logic [31:0] data,
                     input logic wr_en, input logic [31:0] exp, input logic use_cnt);
    steps.push_back('{op, addr, data, wr_en, exp, use_cnt});
  endtask

  task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
    int cycles;
    @(posedge up_clk);
    up_rreq <= 1'b1;
    up_raddr <= addr;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    cycles = 1;
    @(negedge up_clk);
    while (!up_rack && cycles < ACK_TIMEOUT) begin
      @(negedge up_clk);
      cycles++;
    end
    checks++;
    if (!up_rack) begin
      errors++;
      $display("read of 0x%03h was never acknowledged (time %0t)", addr, $time);
    end else if (cycles != 1) begin
      errors++;
      $display("error %0t: read of 0x%03h acknowledged after %0d cycles", $time, addr, cycles);
    end
    data = up_rdata;
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data, input logic wr_en);
    int cycles;
    @(posedge up_clk);
    up_wreq <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    up_cfg_is_writeable <= wr_en;
    @(posedge up_clk);
    up_wreq <= 1'b0;
    cycles = 1;
    @(negedge up_clk);
    while (!up_wack && cycles < ACK_TIMEOUT) begin
      @(negedge up_clk);
      cycles++;
    end
    checks++;
    if (!up_wack) begin
      errors++;
      $display("write to 0x%03h was never acknowledged (time %0t)", addr, $time);
    end else if (cycles != 1) begin
      errors++;
      $display("error %0t: write to 0x%03h acknowledged after %0d cycles", $time, addr, cycles);
    end
  endtask

  // status crosses clock domains, so keep reading until it lands.
  task automatic poll_read(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    int n;
    n = 0;
    bus_read(addr, rd);
    while (rd !== exp && n < POLL_TIMEOUT) begin
      bus_read(addr, rd);
      n++;
    end
    checks++;
    if (rd !== exp) begin
      errors++;
      $display("polling 0x%03h timed out at %0t, last read 0x%08h, expected 0x%08h",
               addr, $time, rd, exp);
    end
  endtask

  task automatic wait_err_ctrl(input logic [7:0] exp);
    int cycles;
    cycles = 0;
    @(negedge core_clk);
    while (DUT.core_err_ctrl != exp && cycles < SYNC_TIMEOUT) begin
      @(negedge core_clk);
      cycles++;
    end
    checks++;
    if (DUT.core_err_ctrl != exp) begin
      errors++;
      $display("error control 0x%02h never reached the core clock domain", exp);
    end
  endtask

  // d[1:0] controller state, d[8*i+8 +: 6] raw lane status {cgs, emb, ifs}.
  task automatic set_status(input logic [31:0] d);
    jesd_rx_status_pkg::lane_status_s [NL-1:0] lanes;
    for (int i = 0; i < NL; i++) begin
      lanes[i] = d[8*i+8 +: 6];
    end
    @(posedge core_clk);
    core_status.ctrl_state <= jesd_rx_status_pkg::ctrl_state_e'(d[1:0]);
    core_status.lane <= lanes;
  endtask

  task automatic drive_flags(input int n);
    jesd_rx_status_pkg::err_mask_t [NL-1:0] flags;
    logic [31:0] f;
    for (int c = 0; c < n; c++) begin
      for (int i = 0; i < NL; i++) begin
        f = $urandom;
        flags[i] = f[6:0];
        if (|(f[6:0] & ~mask_model)) cnt_model[i]++;  // counted once per cycle.
      end
      @(posedge core_clk);
      core_err_flags <= flags;
    end
    @(posedge core_clk);
    core_err_flags <= '0;
  endtask

  task automatic drive_ilas();
    jesd_rx_status_pkg::ilas_word_s [NL-1:0] words;
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < NL; i++) begin
        words[i] = {1'b1, 2'(k), ilas_val(i, k)};
      end
      @(posedge core_clk);
      core_ilas <= words;
    end
    @(posedge core_clk);
    core_ilas <= '0;
  endtask

  task automatic build_table();
    // reset values and unmapped words.
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_BUFFER_SIZE, 0, 0, 32'd256, 0);
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_RX_CFG, 0, 0, 0, 0);
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_ERR_CTRL, 0, 0, 0, 0);
    add(OP_RD, 12'h200, 0, 0, 0, 0);
    add(OP_RD, lane_addr(0, 2), 0, 0, 0, 0);
    // config is locked, then open.
    add(OP_WR, jesd_rx_regmap_pkg::ADDR_RX_CFG, 32'hffff_fd5a, 0, 0, 0);
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_RX_CFG, 0, 0, 0, 0);
    add(OP_CFG, 0, 0, 0, 0, 0);
    add(OP_WR, jesd_rx_regmap_pkg::ADDR_RX_CFG, 32'hffff_fd5a, 1, 0, 0);
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_RX_CFG, 0, 1, cfg_word(1'b1, 8'h56), 0);
    add(OP_CFG, 0, 0, 1, cfg_word(1'b1, 8'h56), 0);
    // link state DATA, lane 0 cgs 2 emb 5, lane 1 cgs 1 emb 3.
    add(OP_STATUS, 0, 32'h0016_2a03, 1, 0, 0);
    add(OP_POLL, jesd_rx_regmap_pkg::ADDR_STATUS, 0, 1, 32'd3, 0);
    add(OP_POLL, lane_addr(0, 0), 0, 1, lane_word(2, 5, 0), 0);
    add(OP_POLL, lane_addr(1, 0), 0, 1, lane_word(1, 3, 0), 0);
    // only error bit 0 counts.
    add(OP_WR, jesd_rx_regmap_pkg::ADDR_ERR_CTRL, 32'h0000_7e00, 1, 0, 0);
    add(OP_RD, jesd_rx_regmap_pkg::ADDR_ERR_CTRL, 0, 1, 32'h0000_7e00, 0);
    add(OP_SYNC, 0, 32'hfc, 1, 0, 0);
    add(OP_FLAGS, 0, 50, 1, 0, 0);
    for (int i = 0; i < NL; i++) add(OP_POLL, lane_addr(i, 1), 0, 1, 0, 1);
    for (int i = 0; i < NL; i++) add(OP_RD, lane_addr(i, 1), 0, 1, 0, 1);
    // clear, then count again with no mask.
    add(OP_WR, jesd_rx_regmap_pkg::ADDR_ERR_CTRL, 32'h0000_7e01, 1, 0, 0);
    add(OP_SYNC, 0, 32'hfd, 1, 0, 0);
    for (int i = 0; i < NL; i++) add(OP_POLL, lane_addr(i, 1), 0, 1, 0, 0);
    add(OP_WR, jesd_rx_regmap_pkg::ADDR_ERR_CTRL, 32'h0, 1, 0, 0);
    add(OP_SYNC, 0, 32'h00, 1, 0, 0);
    add(OP_FLAGS, 0, 30, 1, 0, 0);
    for (int i = 0; i < NL; i++) add(OP_POLL, lane_addr(i, 1), 0, 1, 0, 1);
    // ilas words hidden until ifs_ready.
    add(OP_ILAS, 0, 0, 1, 0, 0);
    for (int i = 0; i < NL; i++)
      for (int k = 0; k < 4; k++) add(OP_RD, lane_addr(i, 4 + k), 0, 1, 0, 0);
    add(OP_STATUS, 0, 32'h0017_2b03, 1, 0, 0);
    add(OP_POLL, lane_addr(0, 0), 0, 1, lane_word(2, 5, 1), 0);
    add(OP_POLL, lane_addr(1, 0), 0, 1, lane_word(1, 3, 1), 0);
    for (int i = 0; i < NL; i++)
      for (int k = 0; k < 4; k++) add(OP_RD, lane_addr(i, 4 + k), 0, 1, ilas_val(i, k), 0);
  endtask

  initial begin
    step_s s;
    logic [31:0] rd;
    logic [31:0] exp;
    int lane;
    rd = $urandom(32'h6be6);
    up_reset = 1'b1;
    core_reset = 1'b1;
    up_rreq = 1'b0;
    up_wreq = 1'b0;
    up_raddr = '0;
    up_waddr = '0;
    up_wdata = '0;
    up_cfg_is_writeable = 1'b0;
    core_status = '0;
    core_err_flags = '0;
    core_ilas = '0;
    mask_model = '0;
    foreach (cnt_model[i]) cnt_model[i] = 0;
    build_table();
    repeat (4) @(posedge up_clk);
    up_reset <= 1'b0;
    core_reset <= 1'b0;
    foreach (steps[n]) begin
      s = steps[n];
      exp = s.exp;
      if (s.use_cnt) begin
        lane = int'((s.addr - jesd_rx_regmap_pkg::LANE_BASE) >> 3);
        exp = cnt_model[lane];
      end
      case (s.op)
        OP_WR: begin
          bus_write(s.addr, s.data, s.wr_en);
          if (s.addr == jesd_rx_regmap_pkg::ADDR_ERR_CTRL) begin
            mask_model = s.data[14:8];
            if (s.data[0]) foreach (cnt_model[i]) cnt_model[i] = 0;
          end
        end
        OP_RD: begin
          bus_read(s.addr, rd);
          checks++;
          if (rd !== exp) begin
            errors++;
            $display("error %0t: read 0x%03h got 0x%08h, expected 0x%08h",
                     $time, s.addr, rd, exp);
          end
        end
        OP_POLL: poll_read(s.addr, exp);
        OP_CFG: begin
          checks++;
          if (cfg_word(up_cfg_buffer_early_release, up_cfg_buffer_delay) !== exp) begin
            errors++;
            $display("error %0t: config outputs 0x%08h, expected 0x%08h", $time,
                     cfg_word(up_cfg_buffer_early_release, up_cfg_buffer_delay), exp);
          end
        end
        OP_STATUS: set_status(s.data);
        OP_SYNC: wait_err_ctrl(s.data[7:0]);
        OP_FLAGS: drive_flags(int'(s.data));
        OP_ILAS: drive_ilas();
        default: ;
      endcase
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
hdl/jesd_rx_regmap_pkg.sv
hdl/jesd_rx_status_pkg.sv
hdl/cdc_bundle_sync.sv
hdl/rx_err_stats.sv
hdl/rx_lane_regs.sv
hdl/rx_ctrl_regs.sv
hdl/jesd_rx_up.sv
tests/tb_jesd_rx_up.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register block testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_jesd_rx_up -f files.f -o sim_tb \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
